/* src.f */
+incdir+testbench
source/pe_pkg.sv
source/posit_mult.sv
source/exp_max_tree.sv
source/align_add_tree.sv
source/mac_lane.sv
source/act_dispatch.sv
source/result_collector.sv
source/pe_top.sv
testbench/tb_top.sv

/* testbench/tb_ref.svh */
`ifndef TB_REF_SVH
`define TB_REF_SVH

//////////////////////////////
// operand helpers
//////////////////////////////

// negative words hold the two's complement of the low seven bits
function automatic int op_magnitude(input logic [pe_pkg::WORD_W-1:0] w);
    int v;
    v = w[pe_pkg::WORD_W-2:0];
    if (w[pe_pkg::WORD_W-1])
        v = (128 - v) % 128;
    return v;
endfunction

// significands with the hidden one, multiplied
function automatic int sig_product(input logic [7:0] a, input logic [7:0] b);
    return (8 + op_magnitude(a) % 8) * (8 + op_magnitude(b) % 8);
endfunction

// exponent before the overflow check, carry included
function automatic int raw_exponent(input logic [7:0] a, input logic [7:0] b);
    int carry;
    carry = (sig_product(a, b) >= 128) ? 1 : 0;
    return op_magnitude(a) / 8 + op_magnitude(b) / 8 + carry;
endfunction

// zero, infinity code or exponent overflow
function automatic bit is_flushed(input logic [7:0] a, input logic [7:0] b);
    return op_magnitude(a) == 0 || op_magnitude(b) == 0 || raw_exponent(a, b) > 15;
endfunction

//////////////////////////////
// one lane's dot product
//////////////////////////////

function automatic pe_pkg::lane_result_t expected_lane_result(
    input logic [pe_pkg::BEAT_W-1:0] act,
    input logic [pe_pkg::BEAT_W-1:0] wrow
);
    int e [16];
    int m [16];
    bit neg [16];
    int emax;
    int total;
    int term;
    pe_pkg::lane_result_t r;
    emax = 0;
    for (int k = 0; k < 16; k++)
    begin
        if (is_flushed(act[k*8 +: 8], wrow[k*8 +: 8]))
        begin
            e[k]   = 0;
            m[k]   = 0;
            neg[k] = 1'b0;
        end
        else
        begin
            e[k]   = raw_exponent(act[k*8 +: 8], wrow[k*8 +: 8]);
            m[k]   = sig_product(act[k*8 +: 8], wrow[k*8 +: 8]);
            neg[k] = act[k*8+7] ^ wrow[k*8+7];
        end
        if (e[k] > emax)
            emax = e[k];
    end
    // four guard bits, then align to the block exponent
    total = 0;
    for (int k = 0; k < 16; k++)
    begin
        term  = (m[k] * 16) >> (emax - e[k]);
        total = neg[k] ? total - term : total + term;
    end
    r.exp = emax[3:0];
    r.sum = total[16:0];
    return r;
endfunction

`endif

/* testbench/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

    localparam int N_LANES    = 4;
    localparam int BUF_DEPTH  = 64;
    localparam int FIFO_DEPTH = 8;
    localparam int BEAT_W     = pe_pkg::BEAT_W;
    localparam int MAX_CYCLES = 4000;
    localparam logic [BEAT_W-1:0] KNOWN_OPS = 128'h0808_1018_212a_f8e8_0b31_d00c_40c7_1928;

    logic                               clk;
    logic                               reset;
    logic                               weight_valid;
    logic [N_LANES-1:0][BEAT_W-1:0]     weight_rows;
    logic                               act_valid;
    logic [BEAT_W-1:0]                  act_data;
    logic                               act_credit;
    logic                               result_valid;
    logic                               result_ready;
    pe_pkg::lane_result_t [N_LANES-1:0] result;

    logic [BEAT_W-1:0]                  wmem [N_LANES][BUF_DEPTH];
    pe_pkg::lane_result_t [N_LANES-1:0] exp_q [$];
    pe_pkg::lane_result_t [N_LANES-1:0] want;
    int n_rows = 0;
    int beat_idx = 0;
    int sent_cnt = 0;
    int ret_cnt = 0;
    int take_cnt = 0;
    int cycles = 0;
    int errors = 0;
    int checks = 0;
    int test_no = 1;
    int tests_failed = 0;
    int err_mark = 0;

    `include "tb_ref.svh"

    pe_top #(
        .N_LANES    (N_LANES),
        .BUF_DEPTH  (BUF_DEPTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) DUT (
        .clk          (clk),
        .reset        (reset),
        .weight_valid (weight_valid),
        .weight_rows  (weight_rows),
        .act_valid    (act_valid),
        .act_data     (act_data),
        .act_credit   (act_credit),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result       (result)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////
    // credits, timeout, compare
    //////////////////////////////

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout after %0d cycles with %0d results outstanding",
                     cycles, exp_q.size());
            $display("=== FAIL ===");
            $finish;
        end
        if (reset)
        begin
            ret_cnt  <= 0;
            take_cnt <= 0;
        end
        else
        begin
            if (act_credit)
                ret_cnt <= ret_cnt + 1;
            if (result_valid && result_ready)
                take_cnt <= take_cnt + 1;
        end
    end

    // pop the oldest expected entry on each transfer
    always @(posedge clk)
    begin
        if (!reset && result_valid && result_ready)
        begin
            assert (exp_q.size() > 0)
            else
            begin
                $display("a result was transferred with no beat outstanding");
                errors++;
            end
            if (exp_q.size() > 0)
            begin
                want = exp_q.pop_front();
                for (int l = 0; l < N_LANES; l++)
                begin
                    checks++;
                    assert (result[l] == want[l])
                    else
                    begin
                        $display("** Error: result[%0d] exp %h sum %h, expected exp %h sum %h",
                                 l, result[l].exp, result[l].sum, want[l].exp, want[l].sum);
                        errors++;
                    end
                end
            end
        end
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic logic [BEAT_W-1:0] random_beat();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    function automatic logic [BEAT_W-1:0] rotate_ops(input logic [BEAT_W-1:0] ops, input int n);
        logic [2*BEAT_W-1:0] twice;
        twice = {ops, ops};
        return twice[n*pe_pkg::WORD_W +: BEAT_W];
    endfunction

    task automatic expect_true(input bit cond, input string what);
        checks++;
        assert (cond)
        else
        begin
            $display("%s", what);
            errors++;
        end
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        reset    = 1'b0;
        sent_cnt = 0;
        beat_idx = 0;
        n_rows   = 0;
        exp_q.delete();
    endtask

    task automatic load_row(input logic [N_LANES-1:0][BEAT_W-1:0] rows);
        weight_rows  = rows;
        weight_valid = 1'b1;
        for (int l = 0; l < N_LANES; l++)
            wmem[l][n_rows] = rows[l];
        n_rows++;
        @(posedge clk);
        #1;
        weight_valid = 1'b0;
    endtask

    task automatic load_random_row();
        logic [N_LANES-1:0][BEAT_W-1:0] rows;
        for (int l = 0; l < N_LANES; l++)
            rows[l] = random_beat();
        load_row(rows);
    endtask

    // waits for a credit and sends with the row the wrap rule picks
    task automatic send_beat(input logic [BEAT_W-1:0] data);
        pe_pkg::lane_result_t [N_LANES-1:0] res;
        int row;
        while (FIFO_DEPTH - sent_cnt + ret_cnt <= 0)
        begin
            @(posedge clk);
            #1;
        end
        row = beat_idx % n_rows;
        for (int l = 0; l < N_LANES; l++)
            res[l] = expected_lane_result(data, wmem[l][row]);
        exp_q.push_back(res);
        act_valid = 1'b1;
        act_data  = data;
        sent_cnt++;
        beat_idx++;
        @(posedge clk);
        #1;
        act_valid = 1'b0;
    endtask

    task automatic drain_results(input bit random_ready);
        result_ready = 1'b1;
        while (exp_q.size() > 0)
        begin
            if (random_ready)
                result_ready = $urandom % 2;
            @(posedge clk);
            #1;
        end
        result_ready = 1'b1;
    endtask

    task automatic end_test(input string name);
        if (errors == err_mark)
            $display("test %0d %s: ok", test_no, name);
        else
        begin
            $display("test %0d %s: %0d errors", test_no, name, errors - err_mark);
            tests_failed++;
        end
        test_no++;
        err_mark = errors;
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////

    initial
    begin
        int n;
        logic [N_LANES-1:0][BEAT_W-1:0] rows;
        reset        = 1'b1;
        weight_valid = 1'b0;
        weight_rows  = '0;
        act_valid    = 1'b0;
        act_data     = '0;
        result_ready = 1'b1;
        void'($urandom(65414));

        // outputs quiet after reset and one full window of credits
        apply_reset();
        result_ready = 1'b0;
        load_random_row();
        repeat (5)
        begin
            expect_true(!result_valid && !act_credit,
                        "result_valid or act_credit high before any beat");
            @(posedge clk);
            #1;
        end
        n = 0;
        while (FIFO_DEPTH - sent_cnt + ret_cnt > 0)
        begin
            send_beat(random_beat());
            n++;
        end
        repeat (4) @(posedge clk);
        #1;
        expect_true(n == FIFO_DEPTH,
                    "beats sent before the first credit differ from the FIFO depth");
        expect_true(ret_cnt == 0, "a credit came back while result_ready was low");
        drain_results(1'b0);
        end_test("reset and credits");

        // known operands with each lane rotated
        apply_reset();
        for (int l = 0; l < N_LANES; l++)
            rows[l] = rotate_ops(KNOWN_OPS, l);
        load_row(rows);
        send_beat({16{8'h08}});
        send_beat(rotate_ops(KNOWN_OPS, 5));
        send_beat({8{8'hf8, 8'h11}});
        drain_results(1'b0);
        end_test("known operands");

        apply_reset();
        repeat (5) load_random_row();
        for (int i = 0; i < 40; i++)
            send_beat(random_beat());
        drain_results(1'b0);
        expect_true(take_cnt == 40, "fewer or more than forty results taken");
        expect_true(ret_cnt == take_cnt, "credits returned differ from results taken");
        end_test("random rows and beats");

        // exponent overflow and zero or infinity codes
        apply_reset();
        for (int l = 0; l < N_LANES; l++)
            rows[l] = {8{8'h10, 8'h78}};
        load_row(rows);
        send_beat({16{8'h48}});
        send_beat({4{8'h38, 8'h38, 8'h80, 8'h00}});
        send_beat({16{8'h80}});
        send_beat({8{8'h00, 8'h09}});
        drain_results(1'b0);
        end_test("flush rules");

        apply_reset();
        repeat (2) load_random_row();
        result_ready = 1'b0;
        while (FIFO_DEPTH - sent_cnt + ret_cnt > 0)
            send_beat(random_beat());
        repeat (6)
        begin
            @(posedge clk);
            #1;
            expect_true(result_valid && !act_credit,
                        "queue not held while result_ready was low");
        end
        drain_results(1'b1);
        expect_true(ret_cnt == FIFO_DEPTH, "not every held result returned a credit");
        end_test("back pressure");

        $display("tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
                 test_no - 1, tests_failed, checks, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

/* source/pe_top.sv */
`timescale 1ns/1ps

module pe_top #(
    parameter int N_LANES    = 4,
    parameter int BUF_DEPTH  = 64,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic                                       weight_valid,
    input  logic [N_LANES-1:0][pe_pkg::BEAT_W-1:0]     weight_rows,
    input  logic                                       act_valid,
    input  logic [pe_pkg::BEAT_W-1:0]                  act_data,
    output logic                                       act_credit,
    output logic                                       result_valid,
    input  logic                                       result_ready,
    output pe_pkg::lane_result_t [N_LANES-1:0]         result
);

    logic [pe_pkg::ROW_W-1:0]                 wr_row;
    logic                                     beat_valid;
    pe_pkg::beat_t                            beat;
    logic [N_LANES-1:0]                       lane_valid;
    pe_pkg::lane_result_t [N_LANES-1:0]       lane_results;

    // input register and row pointers
    act_dispatch u_dispatch (
        .clk          (clk),
        .reset        (reset),
        .weight_valid (weight_valid),
        .act_valid    (act_valid),
        .act_data     (act_data),
        .wr_row       (wr_row),
        .beat_valid   (beat_valid),
        .beat         (beat)
    );

    //////////////////////////////
    // lanes
    //////////////////////////////

    // same beat to every lane, own weight row each
    for (genvar i = 0; i < N_LANES; i++)
    begin : g_lane
        mac_lane #(
            .BUF_DEPTH (BUF_DEPTH)
        ) u_lane (
            .clk          (clk),
            .reset        (reset),
            .weight_valid (weight_valid),
            .wr_row       (wr_row),
            .weight_row   (weight_rows[i]),
            .beat_valid   (beat_valid),
            .beat         (beat),
            .lane_valid   (lane_valid[i]),
            .lane_result  (lane_results[i])
        );
    end

    // lanes run in lock step, lane 0 speaks for all
    result_collector #(
        .N_LANES    (N_LANES),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_collector (
        .clk          (clk),
        .reset        (reset),
        .lane_valid   (lane_valid[0]),
        .lane_results (lane_results),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result       (result),
        .act_credit   (act_credit)
    );

endmodule

/* source/result_collector.sv */
`timescale 1ns/1ps

module result_collector #(
    parameter int N_LANES    = 4,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 lane_valid,
    input  pe_pkg::lane_result_t [N_LANES-1:0]   lane_results,
    output logic                                 result_valid,
    input  logic                                 result_ready,
    output pe_pkg::lane_result_t [N_LANES-1:0]   result,
    output logic                                 act_credit
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    pe_pkg::lane_result_t [N_LANES-1:0] fifo_mem [FIFO_DEPTH];
    logic [PTR_W-1:0]                   wr_ptr;
    logic [PTR_W-1:0]                   rd_ptr;
    logic [CNT_W-1:0]                   count;
    logic                               push;
    logic                               pop;

    // credits held by the source keep the queue from overflowing
    assign push = lane_valid;
    assign pop  = result_valid && result_ready;

    assign result_valid = (count != '0);
    assign result       = fifo_mem[rd_ptr];

    // every slot freed goes back to the source as a credit
    assign act_credit = pop;

    always_ff @(posedge clk)
    begin
        if (push)
            fifo_mem[wr_ptr] <= lane_results;
    end

    //////////////////////////////
    // pointers and occupancy
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* source/act_dispatch.sv */
`timescale 1ns/1ps

module act_dispatch (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         weight_valid,
    input  logic                         act_valid,
    input  logic [pe_pkg::BEAT_W-1:0]    act_data,
    output logic [pe_pkg::ROW_W-1:0]     wr_row,
    output logic                         beat_valid,
    output pe_pkg::beat_t                beat
);

    logic [pe_pkg::ROW_W-1:0] wr_ptr;
    logic [pe_pkg::ROW_W-1:0] rd_ptr;
    logic [pe_pkg::ROW_W-1:0] rd_next;

    assign wr_row = wr_ptr;

    // write pointer doubles as the loaded row count
    always_ff @(posedge clk)
    begin
        if (reset)
            wr_ptr <= '0;
        else if (weight_valid)
            wr_ptr <= wr_ptr + 1'b1;
    end

    // wrap back to row 0 once past the last loaded row
    always_comb
    begin
        rd_next = rd_ptr + 1'b1;
        if (rd_next == wr_ptr)
            rd_next = '0;
    end

    //////////////////////////////
    // beat register
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_ptr     <= '0;
            beat_valid <= 1'b0;
        end
        else
        begin
            beat_valid <= act_valid;
            if (act_valid)
                rd_ptr <= rd_next;
        end
    end

    // payload only, valid bit above qualifies it
    always_ff @(posedge clk)
    begin
        if (act_valid)
        begin
            beat.ops <= act_data;
            beat.row <= rd_ptr;
        end
    end

endmodule

/* source/mac_lane.sv */
`timescale 1ns/1ps

module mac_lane #(
    parameter int BUF_DEPTH = 64
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         weight_valid,
    input  logic [pe_pkg::ROW_W-1:0]     wr_row,
    input  logic [pe_pkg::BEAT_W-1:0]    weight_row,
    input  logic                         beat_valid,
    input  pe_pkg::beat_t                beat,
    output logic                         lane_valid,
    output pe_pkg::lane_result_t         lane_result
);

    logic [pe_pkg::BEAT_W-1:0]                      wbuf [BUF_DEPTH];
    logic [pe_pkg::BEAT_W-1:0]                      act_ops;
    logic [pe_pkg::BEAT_W-1:0]                      wgt_ops;
    logic                                           op_valid;
    pe_pkg::prod_t [pe_pkg::OPS_PER_BEAT-1:0]       prods;
    logic [pe_pkg::EXP_W-1:0]                       max_exp;
    logic signed [pe_pkg::SUM_W-1:0]                sum;

    //////////////////////////////
    // weight buffer
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (weight_valid)
            wbuf[wr_row] <= weight_row;
    end

    // stage 1: operand register, row read alongside the beat
    always_ff @(posedge clk)
    begin
        if (beat_valid)
        begin
            act_ops <= beat.ops;
            wgt_ops <= wbuf[beat.row];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            op_valid   <= 1'b0;
            lane_valid <= 1'b0;
        end
        else
        begin
            op_valid   <= beat_valid;
            lane_valid <= op_valid;
        end
    end

    //////////////////////////////
    // multiply, align, add
    //////////////////////////////

    // operand k of the beat against operand k of the row
    for (genvar k = 0; k < pe_pkg::OPS_PER_BEAT; k++)
    begin : g_mult
        posit_mult u_mult (
            .a    (act_ops[k*pe_pkg::WORD_W +: pe_pkg::WORD_W]),
            .b    (wgt_ops[k*pe_pkg::WORD_W +: pe_pkg::WORD_W]),
            .prod (prods[k])
        );
    end

    exp_max_tree u_max (
        .prods   (prods),
        .max_exp (max_exp)
    );

    align_add_tree u_add (
        .prods   (prods),
        .max_exp (max_exp),
        .sum     (sum)
    );

    // stage 2: result register
    always_ff @(posedge clk)
    begin
        if (op_valid)
        begin
            lane_result.exp <= max_exp;
            lane_result.sum <= sum;
        end
    end

endmodule

/* source/align_add_tree.sv */
`timescale 1ns/1ps

module align_add_tree (
    input  pe_pkg::prod_t [pe_pkg::OPS_PER_BEAT-1:0] prods,
    input  logic [pe_pkg::EXP_W-1:0]                 max_exp,
    output logic signed [pe_pkg::SUM_W-1:0]          sum
);

    localparam int GUARD_W = pe_pkg::ALIGN_W - pe_pkg::PROD_MANT_W;

    logic [pe_pkg::EXP_W-1:0]          shamt [16];
    logic [pe_pkg::ALIGN_W-1:0]        mag   [16];
    logic signed [pe_pkg::ALIGN_W:0]   term  [16];
    logic signed [pe_pkg::ALIGN_W+1:0] lvl1  [8];
    logic signed [pe_pkg::ALIGN_W+2:0] lvl2  [4];
    logic signed [pe_pkg::ALIGN_W+3:0] lvl3  [2];

    //////////////////////////////
    // alignment
    //////////////////////////////

    for (genvar k = 0; k < 16; k++)
    begin : g_term
        // block exponent is never below a product exponent
        assign shamt[k] = max_exp - prods[k].exp;
        assign mag[k]   = {prods[k].mant, {GUARD_W{1'b0}}} >> shamt[k];
        assign term[k]  = prods[k].sign ? -$signed({1'b0, mag[k]}) : $signed({1'b0, mag[k]});
    end

    //////////////////////////////
    // adder tree
    //////////////////////////////

    // one bit of growth per level
    for (genvar k = 0; k < 8; k++)
    begin : g_add1
        assign lvl1[k] = term[2*k] + term[2*k+1];
    end

    for (genvar k = 0; k < 4; k++)
    begin : g_add2
        assign lvl2[k] = lvl1[2*k] + lvl1[2*k+1];
    end

    for (genvar k = 0; k < 2; k++)
    begin : g_add3
        assign lvl3[k] = lvl2[2*k] + lvl2[2*k+1];
    end

    assign sum = lvl3[0] + lvl3[1];

endmodule

/* source/exp_max_tree.sv */
`timescale 1ns/1ps

module exp_max_tree (
    input  pe_pkg::prod_t [pe_pkg::OPS_PER_BEAT-1:0] prods,
    output logic [pe_pkg::EXP_W-1:0]                 max_exp
);

    logic [pe_pkg::EXP_W-1:0] lvl0 [16];
    logic [pe_pkg::EXP_W-1:0] lvl1 [8];
    logic [pe_pkg::EXP_W-1:0] lvl2 [4];
    logic [pe_pkg::EXP_W-1:0] lvl3 [2];

    for (genvar k = 0; k < 16; k++)
    begin : g_l0
        assign lvl0[k] = prods[k].exp;
    end

    // pairwise maximum, halving each level
    for (genvar k = 0; k < 8; k++)
    begin : g_l1
        assign lvl1[k] = (lvl0[2*k] > lvl0[2*k+1]) ? lvl0[2*k] : lvl0[2*k+1];
    end

    for (genvar k = 0; k < 4; k++)
    begin : g_l2
        assign lvl2[k] = (lvl1[2*k] > lvl1[2*k+1]) ? lvl1[2*k] : lvl1[2*k+1];
    end

    for (genvar k = 0; k < 2; k++)
    begin : g_l3
        assign lvl3[k] = (lvl2[2*k] > lvl2[2*k+1]) ? lvl2[2*k] : lvl2[2*k+1];
    end

    assign max_exp = (lvl3[0] > lvl3[1]) ? lvl3[0] : lvl3[1];

endmodule

/* source/posit_mult.sv */
`timescale 1ns/1ps

module posit_mult (
    input  logic [pe_pkg::WORD_W-1:0] a,
    input  logic [pe_pkg::WORD_W-1:0] b,
    output pe_pkg::prod_t             prod
);

    localparam int MAG_W = pe_pkg::WORD_W - 1;

    logic [MAG_W-1:0]               mag_a;
    logic [MAG_W-1:0]               mag_b;
    logic [pe_pkg::PROD_MANT_W-1:0] sig_prod;
    logic [pe_pkg::EXP_W:0]         exp_sum;
    logic                           flush;

    // negative words hold the two's complement of the low bits
    function automatic logic [MAG_W-1:0] to_mag(input logic [pe_pkg::WORD_W-1:0] w);
        if (w[pe_pkg::WORD_W-1])
            return ~w[MAG_W-1:0] + 1'b1;
        return w[MAG_W-1:0];
    endfunction

    assign mag_a = to_mag(a);
    assign mag_b = to_mag(b);

    // hidden ones restored before the multiply
    assign sig_prod = {1'b1, mag_a[pe_pkg::FRAC_W-1:0]} * {1'b1, mag_b[pe_pkg::FRAC_W-1:0]};

    // carry out of the significand bumps the exponent
    assign exp_sum = mag_a[MAG_W-1 -: pe_pkg::EXP_W] + mag_b[MAG_W-1 -: pe_pkg::EXP_W]
                   + sig_prod[pe_pkg::PROD_MANT_W-1];

    // zero and infinity codes both decode to magnitude 0
    assign flush = (mag_a == '0) || (mag_b == '0) || exp_sum[pe_pkg::EXP_W];

    always_comb
    begin
        if (flush)
        begin
            prod.sign = 1'b0;
            prod.zero = 1'b1;
            prod.exp  = '0;
            prod.mant = '0;
        end
        else
        begin
            prod.sign = a[pe_pkg::WORD_W-1] ^ b[pe_pkg::WORD_W-1];
            prod.zero = 1'b0;
            prod.exp  = exp_sum[pe_pkg::EXP_W-1:0];
            prod.mant = sig_prod;
        end
    end

endmodule

/* source/pe_pkg.sv */
package pe_pkg;

    //////////////////////////////
    // operand format
    //////////////////////////////

    // sign, 4-bit exponent, 3-bit fraction
    localparam int WORD_W = 8;
    localparam int EXP_W = 4;
    localparam int FRAC_W = 3;

    localparam int OPS_PER_BEAT = 16;
    localparam int BEAT_W = WORD_W * OPS_PER_BEAT;

    // weight row index carried with each beat
    localparam int ROW_W = 6;

    //////////////////////////////
    // datapath widths
    //////////////////////////////

    // product of two hidden-one significands, not normalized
    localparam int PROD_MANT_W = 2 * (FRAC_W + 1);

    // product mantissa plus four guard zeros
    localparam int ALIGN_W = PROD_MANT_W + 4;

    // sixteen signed terms, one extra bit per adder level
    localparam int SUM_W = ALIGN_W + 1 + 4;

    // one multiplier output
    typedef struct packed {
        logic                   sign;
        logic                   zero;
        logic [EXP_W-1:0]       exp;
        logic [PROD_MANT_W-1:0] mant;
    } prod_t;

    // accepted activation beat and the weight row it pairs with
    typedef struct packed {
        logic [BEAT_W-1:0] ops;
        logic [ROW_W-1:0]  row;
    } beat_t;

    // block exponent with the signed sum of aligned products
    typedef struct packed {
        logic [EXP_W-1:0]        exp;
        logic signed [SUM_W-1:0] sum;
    } lane_result_t;

endpackage
